//--- patch_engine.f
+incdir+rtl
rtl/patch_pkg.sv
rtl/mem_ctrl.sv
rtl/patch_ctrl.sv
rtl/patch_loader.sv
rtl/patch_out.sv
rtl/patch_engine.sv
dv/patch_engine_props.sv
dv/patch_engine_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module patch_engine_tb -f patch_engine.f -o patch_engine_sim \
    && ./obj_dir/patch_engine_sim | tee /dev/stderr | grep -q "=== PASS ===" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- dv/patch_engine_tb.sv
`timescale 1ns/1ns
`include "patch_settings.svh"

module patch_engine_tb import patch_pkg::*; ();

    localparam int THREADS   = `PATCH_THREADS;
    localparam int COLS      = 2 ** `IMG_COLS_LOG2;
    localparam int FRAME_PIX = 2 ** `PIX_ID_W;
    localparam int ID_W      = `PIX_ID_W;

    logic        clk;
    logic        rst_n;
    logic        wr_en;
    pixel_id_u   wr_addr;
    pixel_data_t wr_data;
    logic        start;
    pixel_cnt_t  pixel_count;
    logic        out_valid;
    pixel_id_u   out_pixel;
    pixel_data_t out_data;
    logic        busy;
    logic        frame_done;

    logic [31:0] lfsr_state = 32'h35ff945e;
    pixel_data_t shadow [FRAME_PIX];   // model of the frame RAM.
    int          exp_q [$];            // ids still due at the outputs, in order.
    int          run_counts [$];       // a negative entry reloads the frame.
    int          cycle_cnt;
    int          cycle_limit;

    patch_engine u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .start       (start),
        .pixel_count (pixel_count),
        .out_valid   (out_valid),
        .out_pixel   (out_pixel),
        .out_data    (out_data),
        .busy        (busy),
        .frame_done  (frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32+x^22+x^2+x+1.
    endfunction

    task automatic rand_bits(input int nbits, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_pixel(input string name, input pixel_id_u exp, input pixel_id_u act);
        if (act !== exp) begin
            report_error($sformatf("FAIL t=%0t %s expected %0d got %0d",
                $time, name, exp.addr, act.addr));
        end
    endtask

    task automatic check_data(input string name, input pixel_data_t exp, input pixel_data_t act);
        if (act !== exp) begin
            report_error($sformatf("FAIL t=%0t %s expected %0h got %0h", $time, name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_error($sformatf("FAIL t=%0t %s expected %b got %b", $time, name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            report_error($sformatf("FAIL t=%0t %s expected %0d got %0d", $time, name, exp, act));
        end
    endtask

    task automatic load_frame();
        int a;
        logic [31:0] r;
        for (a = 0; a < FRAME_PIX; a++) begin
            @(negedge clk);
            check_flag("busy", 1'b0, busy);
            check_flag("out_valid", 1'b0, out_valid);
            rand_bits(`PIX_DATA_W, r);
            wr_en        = 1'b1;
            wr_addr.addr = ID_W'(a);
            wr_data      = pixel_data_t'(r);
            shadow[a]    = pixel_data_t'(r);
        end
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    task automatic run_frame(input int n);
        int          i;
        int          cyc;
        int          burst;
        int          id;
        bit          done_seen;
        pixel_id_u   exp_pix;
        pixel_id_u   junk_addr;
        logic [31:0] r;
        for (i = 0; i < n; i++) begin
            exp_q.push_back(i);
        end
        @(negedge clk);
        start       = 1'b1;
        pixel_count = pixel_cnt_t'(n);
        cyc         = 0;
        burst       = 0;
        done_seen   = 1'b0;
        while (!done_seen) begin
            @(negedge clk);
            cyc++;
            start = 1'b0;
            wr_en = 1'b0;
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    report_error($sformatf("out_valid at %0t with no pixel left to output",
                        $time));
                end else begin
                    id = exp_q.pop_front();
                    exp_pix.addr = ID_W'(id);
                    check_pixel("out_pixel", exp_pix, out_pixel);
                    check_data("out_data", shadow[id], out_data);
                    check_count("out_pixel.rc.row", id / COLS, int'(out_pixel.rc.row));
                    check_count("out_pixel.rc.col", id % COLS, int'(out_pixel.rc.col));
                    burst++;
                end
            end else if (burst != 0) begin
                if (exp_q.size() != 0) begin
                    check_count("out_valid burst length", THREADS, burst); // full batch.
                end else if (burst > THREADS) begin
                    report_error($sformatf("last out_valid burst of %0d cycles is too long",
                        burst));
                end
                burst = 0;
            end
            if (frame_done) begin
                if (exp_q.size() != 0) begin
                    report_error($sformatf("frame_done at %0t with %0d pixels never output",
                        $time, exp_q.size()));
                end
                done_seen = 1'b1;
            end
            if (cyc == 2) begin
                // a write and a start mid run, both must be dropped.
                check_flag("busy", 1'b1, busy);
                rand_bits(ID_W, r);
                junk_addr.addr = ID_W'(r);
                wr_en   = 1'b1;
                wr_addr = junk_addr;
                wr_data = ~shadow[junk_addr.addr];
                rand_bits(`PIX_CNT_W, r);
                start       = 1'b1;
                pixel_count = pixel_cnt_t'(r);
            end
        end
        do begin
            @(negedge clk);
            check_flag("out_valid", 1'b0, out_valid);
            check_flag("frame_done", 1'b0, frame_done);
        end while (busy);
    endtask

    initial begin
        cycle_cnt = 0;
        forever begin
            @(posedge clk);
            cycle_cnt++;
            if (cycle_cnt > cycle_limit) begin
                report_error($sformatf("timeout after %0d cycles, the DUT looks hung",
                    cycle_limit));
            end
        end
    end

    initial begin
        int          i;
        logic [31:0] r;
        rst_n       = 1'b0;
        wr_en       = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        start       = 1'b0;
        pixel_count = '0;
        run_counts.push_back(FRAME_PIX);
        run_counts.push_back(0);
        run_counts.push_back(1);
        run_counts.push_back(THREADS);
        run_counts.push_back(THREADS + 1);
        run_counts.push_back(FRAME_PIX - 1);
        run_counts.push_back(-1);
        for (i = 0; i < 6; i++) begin
            rand_bits(`PIX_CNT_W, r);
            run_counts.push_back(int'(r) % (FRAME_PIX + 1));
        end
        run_counts.push_back(FRAME_PIX); // sees every busy-time write that was dropped.
        cycle_limit = 2 * 64 + FRAME_PIX;
        for (i = 0; i < run_counts.size(); i++) begin
            if (run_counts[i] < 0) begin
                cycle_limit += FRAME_PIX + 8;
            end else begin
                cycle_limit += 3 * run_counts[i] + 64;
            end
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (8) begin
            @(negedge clk);
            check_flag("out_valid", 1'b0, out_valid);
            check_flag("busy", 1'b0, busy);
            check_flag("frame_done", 1'b0, frame_done);
        end
        load_frame();
        for (i = 0; i < run_counts.size(); i++) begin
            if (run_counts[i] < 0) begin
                load_frame();
            end else begin
                run_frame(run_counts[i]);
            end
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- dv/patch_engine_props.sv
`timescale 1ns/1ns
`include "patch_settings.svh"

module patch_engine_props (
    input logic clk,
    input logic rst_n,
    input logic load_start,
    input logic load_done,
    input logic load_done_term,
    input logic id_valid
);

    localparam int THREADS = `PATCH_THREADS;
    localparam int RUN_W   = $clog2(THREADS + 1);

    logic [RUN_W-1:0] id_run; // ids issued since the last batch boundary.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_run <= '0;
        end else if (load_done) begin
            id_run <= '0;
        end else if (id_valid) begin
            id_run <= id_run + 1'b1;
        end
    end

    a_start_done_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(load_start && load_done))
        else $error("load_start and load_done high in the same cycle");

    // only the final batch may close with fewer ids than lanes.
    a_short_batch_last: assert property (@(posedge clk) disable iff (!rst_n)
        (load_done && !load_done_term) |-> (id_run == RUN_W'(THREADS)))
        else $error("a batch closed short of the lane count but was not the last");

    a_batch_size: assert property (@(posedge clk) disable iff (!rst_n)
        id_valid |-> (id_run < RUN_W'(THREADS)))
        else $error("more ids in one batch than there are lanes");

endmodule

bind patch_ctrl patch_engine_props u_props (
    .clk            (clk),
    .rst_n          (rst_n),
    .load_start     (load_start),
    .load_done      (load_done),
    .load_done_term (load_done_term),
    .id_valid       (id_valid)
);

//--- rtl/patch_engine.sv
`timescale 1ns/1ns
`include "patch_settings.svh"

module patch_engine import patch_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wr_en,
    input  pixel_id_u   wr_addr,
    input  pixel_data_t wr_data,
    input  logic        start,
    input  pixel_cnt_t  pixel_count,
    output logic        out_valid,
    output pixel_id_u   out_pixel,
    output pixel_data_t out_data,
    output logic        busy,
    output logic        frame_done
);

    localparam int LI_W   = $clog2(`PATCH_THREADS);
    localparam int CNT_W  = $clog2(`PATCH_THREADS + 1);
    localparam int LANE_W = `PIX_ID_W + `PIX_DATA_W;

    logic              we_pixel_size;
    pixel_cnt_t        pixel_size;
    logic              init_mem_fin;
    logic              load_start;
    logic              load_done;
    logic              load_done_term;
    pixel_id_u         pixel_id;
    pixel_id_u         rd_addr;
    pixel_data_t       rd_data;
    logic              batch_ready;
    logic [CNT_W-1:0]  batch_count;
    logic              batch_last;
    logic [LI_W-1:0]   lane_idx;
    logic [LANE_W-1:0] lane_data;
    logic              patch_out_done;

    mem_ctrl u_mem_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .start         (start),
        .pixel_count   (pixel_count),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .frame_done    (frame_done),
        .we_pixel_size (we_pixel_size),
        .pixel_size    (pixel_size),
        .init_mem_fin  (init_mem_fin),
        .busy          (busy)
    );

    patch_ctrl u_patch_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .init_mem_fin   (init_mem_fin),
        .patch_out_done (patch_out_done),
        .pixel_size     (pixel_size),
        .we_pixel_size  (we_pixel_size),
        .load_start     (load_start),
        .load_done      (load_done),
        .load_done_term (load_done_term),
        .pixel_id       (pixel_id)
    );

    patch_loader u_patch_loader (
        .clk            (clk),
        .rst_n          (rst_n),
        .load_start     (load_start),
        .load_done      (load_done),
        .load_done_term (load_done_term),
        .pixel_id       (pixel_id),
        .rd_data        (rd_data),
        .lane_idx       (lane_idx),
        .rd_addr        (rd_addr),
        .lane_data      (lane_data),
        .batch_ready    (batch_ready),
        .batch_count    (batch_count),
        .batch_last     (batch_last)
    );

    patch_out u_patch_out (
        .clk            (clk),
        .rst_n          (rst_n),
        .batch_ready    (batch_ready),
        .batch_count    (batch_count),
        .batch_last     (batch_last),
        .lane_data      (lane_data),
        .lane_idx       (lane_idx),
        .out_valid      (out_valid),
        .out_pixel      (out_pixel),
        .out_data       (out_data),
        .patch_out_done (patch_out_done),
        .frame_done     (frame_done)
    );

endmodule

//--- rtl/patch_out.sv
`timescale 1ns/1ns
`include "patch_settings.svh"

module patch_out import patch_pkg::*; (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   batch_ready,
    input  logic [$clog2(`PATCH_THREADS+1)-1:0]    batch_count,
    input  logic                                   batch_last,
    input  logic [`PIX_ID_W+`PIX_DATA_W-1:0]       lane_data,
    output logic [$clog2(`PATCH_THREADS)-1:0]      lane_idx,
    output logic                                   out_valid,
    output pixel_id_u                              out_pixel,
    output pixel_data_t                            out_data,
    output logic                                   patch_out_done,
    output logic                                   frame_done
);

    localparam int THREADS = `PATCH_THREADS;
    localparam int LI_W    = $clog2(THREADS);
    localparam int CNT_W   = $clog2(THREADS + 1);

    logic             draining;
    logic [LI_W-1:0]  drain_idx;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] total;
    logic             last_q;
    logic             empty;
    logic             issue;       // a lane moves to the outputs this cycle.
    logic             issue_last;
    logic             out_last;

    assign lane_idx   = drain_idx;
    assign total      = draining ? cnt_q : batch_count;
    assign empty      = batch_ready & (batch_count == '0);
    assign issue      = draining | (batch_ready & (batch_count != '0));
    assign issue_last = issue & ((CNT_W'(drain_idx) + 1'b1) == total);

    always_ff @(posedge clk) begin
        if (issue) begin
            {out_pixel, out_data} <= lane_data;
        end
        if (batch_ready) begin
            cnt_q  <= batch_count;
            last_q <= batch_last;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            draining       <= 1'b0;
            drain_idx      <= '0;
            out_valid      <= 1'b0;
            out_last       <= 1'b0;
            patch_out_done <= 1'b0;
            frame_done     <= 1'b0;
        end else begin
            out_valid      <= issue;
            out_last       <= issue_last;
            patch_out_done <= (out_last & ~last_q) | (empty & ~batch_last);
            frame_done     <= (out_last & last_q) | (empty & batch_last);
            if (issue_last) begin
                draining  <= 1'b0;
                drain_idx <= '0;  // ready for the next batch.
            end else if (issue) begin
                draining  <= 1'b1;
                drain_idx <= drain_idx + 1'b1;
            end
        end
    end

endmodule

//--- rtl/patch_loader.sv
`timescale 1ns/1ns
`include "patch_settings.svh"

module patch_loader import patch_pkg::*; (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   load_start,
    input  logic                                   load_done,
    input  logic                                   load_done_term,
    input  pixel_id_u                              pixel_id,
    input  pixel_data_t                            rd_data,
    input  logic [$clog2(`PATCH_THREADS)-1:0]      lane_idx,
    output pixel_id_u                              rd_addr,
    output logic [`PIX_ID_W+`PIX_DATA_W-1:0]       lane_data,
    output logic                                   batch_ready,
    output logic [$clog2(`PATCH_THREADS+1)-1:0]    batch_count,
    output logic                                   batch_last
);

    localparam int THREADS = `PATCH_THREADS;
    localparam int LI_W    = $clog2(THREADS);
    localparam int CNT_W   = $clog2(THREADS + 1);
    localparam int LANE_W  = `PIX_ID_W + `PIX_DATA_W;

    logic [LANE_W-1:0] lane_mem [THREADS]; // {id, data} per lane.

    logic             loading;
    logic             id_valid;
    logic             fill_vld;  // read data for fill_id arrives now.
    pixel_id_u        fill_id;
    logic [CNT_W-1:0] fill_cnt;

    assign rd_addr   = pixel_id;
    assign id_valid  = load_start | (loading & ~load_done);
    assign lane_data = lane_mem[lane_idx];

    always_ff @(posedge clk) begin
        fill_id <= pixel_id;
        if (fill_vld) begin
            lane_mem[fill_cnt[LI_W-1:0]] <= {fill_id, rd_data};
        end
        // the last lane lands in the load_done cycle, so count it here.
        if (load_done) begin
            batch_count <= fill_cnt + CNT_W'(fill_vld);
            batch_last  <= load_done_term;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            loading     <= 1'b0;
            fill_vld    <= 1'b0;
            fill_cnt    <= '0;
            batch_ready <= 1'b0;
        end else begin
            if (load_start) begin
                loading <= 1'b1;
            end else if (load_done) begin
                loading <= 1'b0;
            end
            fill_vld <= id_valid;
            if (load_done) begin
                fill_cnt <= '0;
            end else if (fill_vld) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
            batch_ready <= load_done;
        end
    end

endmodule

//--- rtl/patch_ctrl.sv
`timescale 1ns/1ns
`include "patch_settings.svh"

module patch_ctrl import patch_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       init_mem_fin,
    input  logic       patch_out_done,
    input  pixel_cnt_t pixel_size,
    input  logic       we_pixel_size,
    output logic       load_start,
    output logic       load_done,
    output logic       load_done_term,
    output pixel_id_u  pixel_id
);

    localparam int THREADS = `PATCH_THREADS;
    localparam int TC_W    = $clog2(THREADS);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_ISSUE = 2'd1;
    localparam logic [1:0] S_WAIT  = 2'd2;

    logic [1:0]      state;
    logic [TC_W-1:0] thread_cnt;
    pixel_cnt_t      pixel_max;
    pixel_id_u       pixel_curr;

    logic id_valid;   // an id is presented this cycle.
    logic last_id;
    logic batch_end;

    assign pixel_id = pixel_curr;

    // a batch opens on init or when the lanes come back free.
    always_comb begin
        case (state)
            S_IDLE:  load_start = init_mem_fin && (pixel_max != '0);
            S_WAIT:  load_start = patch_out_done;
            default: load_start = 1'b0;
        endcase
    end

    assign id_valid  = load_start | (state == S_ISSUE);
    assign last_id   = ({1'b0, pixel_curr.addr} + 1'b1) == pixel_max;
    assign batch_end = last_id | (thread_cnt == TC_W'(THREADS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pixel_max <= '0;
        end else if (we_pixel_size) begin
            pixel_max <= pixel_size;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= S_IDLE;
            thread_cnt     <= '0;
            pixel_curr     <= '0;
            load_done      <= 1'b0;
            load_done_term <= 1'b0;
        end else begin
            load_done      <= 1'b0;
            load_done_term <= 1'b0;
            if (id_valid) begin
                if (last_id) begin
                    // final id, close out the run.
                    state          <= S_IDLE;
                    thread_cnt     <= '0;
                    pixel_curr     <= '0;
                    load_done      <= 1'b1;
                    load_done_term <= 1'b1;
                end else if (batch_end) begin
                    state           <= S_WAIT;
                    thread_cnt      <= '0;
                    pixel_curr.addr <= pixel_curr.addr + 1'b1; // next id waits here.
                    load_done       <= 1'b1;
                end else begin
                    state           <= S_ISSUE;
                    thread_cnt      <= thread_cnt + 1'b1;
                    pixel_curr.addr <= pixel_curr.addr + 1'b1;
                end
            end else if ((state == S_IDLE) && init_mem_fin) begin
                // zero count, an empty last batch.
                load_done      <= 1'b1;
                load_done_term <= 1'b1;
            end
        end
    end

endmodule

//--- rtl/mem_ctrl.sv
`timescale 1ns/1ns
`include "patch_settings.svh"

module mem_ctrl import patch_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wr_en,
    input  pixel_id_u   wr_addr,
    input  pixel_data_t wr_data,
    input  logic        start,
    input  pixel_cnt_t  pixel_count,
    input  pixel_id_u   rd_addr,
    output pixel_data_t rd_data,
    input  logic        frame_done,
    output logic        we_pixel_size,
    output pixel_cnt_t  pixel_size,
    output logic        init_mem_fin,
    output logic        busy
);

    localparam int DEPTH = 2 ** `PIX_ID_W;

    pixel_data_t frame_mem [DEPTH];

    logic run_req;  // start taken, busy rises next edge.
    logic active;
    logic accept;

    assign active = busy | run_req;
    assign accept = start & ~active;

    // host writes are locked out for the whole run.
    always_ff @(posedge clk) begin
        if (wr_en && !active) begin
            frame_mem[wr_addr.addr] <= wr_data;
        end
        rd_data <= frame_mem[rd_addr.addr]; // one cycle read latency.
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pixel_size <= pixel_count;
        end
    end

    // size strobe, then init strobe on the following cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_req       <= 1'b0;
            we_pixel_size <= 1'b0;
            init_mem_fin  <= 1'b0;
            busy          <= 1'b0;
        end else begin
            run_req       <= accept;
            we_pixel_size <= run_req;
            init_mem_fin  <= we_pixel_size;
            if (run_req) begin
                busy <= 1'b1;
            end else if (frame_done) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

//--- rtl/patch_pkg.sv
`include "patch_settings.svh"

package patch_pkg;

    // one pixel id, read as a frame address or as row and column.
    typedef union packed {
        logic [`PIX_ID_W-1:0] addr;
        struct packed {
            logic [`IMG_ROWS_LOG2-1:0] row;
            logic [`IMG_COLS_LOG2-1:0] col;
        } rc;
    } pixel_id_u;

    typedef logic [`PIX_DATA_W-1:0] pixel_data_t;

    typedef logic [`PIX_CNT_W-1:0] pixel_cnt_t;

endpackage

//--- rtl/patch_settings.svh
`ifndef PATCH_SETTINGS_SVH
`define PATCH_SETTINGS_SVH

// lanes gathered per batch.
`define PATCH_THREADS 8

// frame geometry, 16 x 16.
`define IMG_COLS_LOG2 4
`define IMG_ROWS_LOG2 4
`define PIX_ID_W      (`IMG_ROWS_LOG2 + `IMG_COLS_LOG2)
`define PIX_DATA_W    8
`define PIX_CNT_W     (`PIX_ID_W + 1) // holds a full frame count.

`endif
